// File: rca_issue.f
hw/rca_pkg.sv
hw/id_fifo.sv
hw/grid_control.sv
hw/rca_unit.sv
hw/rca_grid.sv
sim/tb_rca_grid.sv

// File: Makefile
FLIST = rca_issue.f

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f $(FLIST) --top-module tb_rca_grid
	verilator --lint-only hw/rca_pkg.sv hw/id_fifo.sv hw/grid_control.sv \
		hw/rca_unit.sv hw/rca_grid.sv --top-module rca_grid

sim:
	verilator --binary --timing --assert -j 0 -f $(FLIST) --top-module tb_rca_grid
	@out="$$(./obj_dir/Vtb_rca_grid)"; echo "$$out"; \
		echo "$$out" | grep -qx 'PASS: all tests'

clean:
	rm -rf obj_dir

// File: sim/tb_rca_grid.sv
module tb_rca_grid;
    import rca_pkg::*;

    localparam int WAIT_LIMIT = 200;  // Longest any single wait may take, in cycles
    localparam rca_sel_t SEL_ADD = rca_sel_t'(RCA_ADD);
    localparam rca_sel_t SEL_MAC = rca_sel_t'(RCA_MAC16);

    logic clk;
    logic rst;
    rca_issue_t issue;
    logic issue_ready;
    logic wb_valid;
    id_t wb_id;
    logic wb_fb_instr;
    rca_result_t wb_result;

    logic [XLEN-1:0] model_acc [NUM_RCAS];  // Reference accumulator per unit
    logic [XLEN-1:0] model_rs1 [NUM_RCAS];  // Operands last loaded into each unit
    logic [XLEN-1:0] model_rs2 [NUM_RCAS];
    id_t exp_id [$];                        // Expected writebacks, oldest first
    bit exp_fb [$];
    rca_result_t exp_res [$];
    id_t next_id;                           // IDs wrap and in-order retire keeps them distinct
    int value_errors;
    int other_errors;
    int wb_count;
    bit timed_out;                          // Set once any wait gives up
    string test_name;

    rca_grid dut_i (.clk, .rst, .issue, .issue_ready,
                    .wb_valid, .wb_id, .wb_fb_instr, .wb_result);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Lane-wise 16-bit multiply-accumulate where each lane wraps on its own
    function automatic logic [XLEN-1:0] mac16_step(input logic [XLEN-1:0] acc,
                                                   input logic [XLEN-1:0] a,
                                                   input logic [XLEN-1:0] b);
        logic [15:0] lo;
        logic [15:0] hi;
        lo = acc[15:0] + a[15:0] * b[15:0];
        hi = acc[31:16] + a[31:16] * b[31:16];
        return {hi, lo};
    endfunction

    function automatic rca_issue_t build_request(input rca_sel_t sel, input bit use_it,
                                                 input bit fb);
        rca_issue_t req;
        req = '0;
        req.new_request = 1'b1;
        req.id = next_id;
        req.rca_sel = sel;
        req.use_instr = use_it;
        req.use_fb_instr = fb;
        req.ops.rs1.word = $urandom();  // Non-feedback requests carry junk the unit must ignore
        req.ops.rs2.word = $urandom();
        return req;
    endfunction

    // Advances the model and queues the writeback the DUT owes for this request
    task automatic record_expected(input rca_issue_t req);
        rca_result_t exp;
        if (req.use_instr) begin
            if (req.use_fb_instr) begin
                model_rs1[req.rca_sel] = req.ops.rs1.word;
                model_rs2[req.rca_sel] = req.ops.rs2.word;
            end
            if (req.rca_sel == SEL_MAC) begin
                model_acc[req.rca_sel] = mac16_step(model_acc[req.rca_sel],
                                                    model_rs1[req.rca_sel],
                                                    model_rs2[req.rca_sel]);
            end else begin
                model_acc[req.rca_sel] = model_acc[req.rca_sel] + model_rs1[req.rca_sel]
                                         + model_rs2[req.rca_sel];
            end
            exp.data.word = model_acc[req.rca_sel];
            exp_id.push_back(req.id);
            exp_fb.push_back(req.use_fb_instr);
            exp_res.push_back(exp);
            next_id = next_id + 1'b1;
        end
    endtask

    task automatic end_run();
        $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    // Later waits and issues are skipped once this is set
    task automatic report_timeout(input string what);
        timed_out = 1'b1;
        other_errors++;
        $display("%s: timed out waiting for %s", test_name, what);
    endtask

    // Returns right after a rising edge at which a request may be driven
    task automatic wait_issue_slot(input int need);
        bit ready_seen;
        int cycles;
        ready_seen = 1'b0;
        cycles = 0;
        while (!ready_seen && !timed_out) begin
            if (cycles == WAIT_LIMIT) begin
                report_timeout("issue_ready and free IDs");
            end else begin
                cycles++;
                @(negedge clk);
                ready_seen = issue_ready;  // No request in this cycle, so it holds past the edge
                @(posedge clk);
                if (exp_id.size() > MAX_IDS - need) ready_seen = 1'b0;  // Issue window is full
            end
        end
    endtask

    task automatic send_instr(input rca_sel_t sel, input bit use_it, input bit fb);
        rca_issue_t req;
        wait_issue_slot(1);
        if (!timed_out) begin
            req = build_request(sel, use_it, fb);
            issue <= req;
            record_expected(req);
            @(posedge clk);
            issue.new_request <= 1'b0;
        end
    endtask

    // Feedback requests on consecutive cycles to one RCA
    task automatic issue_burst(input rca_sel_t sel, input int n);
        rca_issue_t req;
        wait_issue_slot(n);
        if (!timed_out) begin
            for (int i = 0; i < n; i++) begin
                req = build_request(sel, 1'b1, 1'b1);
                issue <= req;
                record_expected(req);
                @(negedge clk);
                if (!issue_ready) begin
                    other_errors++;
                    $display("%s: issue_ready dropped during a same-RCA burst", test_name);
                end
                @(posedge clk);
            end
            issue.new_request <= 1'b0;
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_id.size() != 0 && !timed_out) begin
            if (cycles == WAIT_LIMIT) begin
                report_timeout("outstanding writebacks");
            end else begin
                cycles++;
                @(posedge clk);
            end
        end
    endtask

    task automatic check_id(input string name, input id_t exp, input id_t act);
        if (act !== exp) begin
            value_errors++;
            $display("[ERROR] %s: wb_id expected %0d got %0d", name, exp, act);
        end
    endtask

    task automatic check_fb(input string name, input bit exp, input bit act);
        if (act !== exp) begin
            value_errors++;
            $display("[ERROR] %s: wb_fb_instr expected %0b got %0b", name, exp, act);
        end
    endtask

    task automatic check_result(input string name, input rca_result_t exp,
                                input rca_result_t act);
        if (act !== exp) begin
            value_errors++;
            $display("[ERROR] %s: wb_result expected %08h got %08h", name,
                     exp.data.word, act.data.word);
        end
    endtask

    // Writeback monitor sampling mid-cycle where the outputs have settled
    initial begin
        forever begin
            @(negedge clk);
            if (!rst && wb_valid) begin
                wb_count++;
                if (exp_id.size() == 0) begin
                    other_errors++;
                    $display("%s: writeback of ID %0d with nothing outstanding",
                             test_name, wb_id);
                end else begin
                    check_id(test_name, exp_id.pop_front(), wb_id);
                    check_fb(test_name, exp_fb.pop_front(), wb_fb_instr);
                    check_result(test_name, exp_res.pop_front(), wb_result);
                end
            end
        end
    end

    task automatic stream_single_rca();
        test_name = "single_stream";
        repeat (MAX_IDS) send_instr(SEL_ADD, 1'b1, 1'b1);
        wait_drain();
    endtask

    task automatic reuse_operands();
        test_name = "operand_reuse";
        send_instr(SEL_ADD, 1'b1, 1'b1);
        send_instr(SEL_ADD, 1'b1, 1'b0);  // Same operands as the load above
        send_instr(SEL_ADD, 1'b1, 1'b0);
        wait_drain();
    endtask

    task automatic mac_lanes();
        test_name = "lane_mac";
        send_instr(SEL_MAC, 1'b1, 1'b1);  // First use of RCA 1 loads its operands
        send_instr(SEL_MAC, 1'b1, 1'b0);
        send_instr(SEL_MAC, 1'b1, 1'b1);
        send_instr(SEL_MAC, 1'b1, 1'b0);
        wait_drain();
    endtask

    task automatic switch_rca();
        test_name = "rca_switch";
        repeat (3) send_instr(SEL_ADD, 1'b1, 1'b1);
        send_instr(SEL_MAC, 1'b1, 1'b0);  // RCA 0 still busy, so this one must wait
        @(negedge clk);
        if (issue_ready) begin
            other_errors++;
            $display("%s: issue_ready stayed high while RCA 0 IDs were in flight", test_name);
        end
        send_instr(SEL_ADD, 1'b1, 1'b0);  // Switching back lets the RCA 0 accumulator carry on
        wait_drain();
    endtask

    task automatic skip_unused_requests();
        test_name = "ignored";
        send_instr(SEL_ADD, 1'b1, 1'b1);
        send_instr(SEL_MAC, 1'b0, 1'b1);  // Other RCA yet neither a switch nor a load
        send_instr(SEL_ADD, 1'b0, 1'b1);
        send_instr(SEL_ADD, 1'b1, 1'b0);  // Must see the operands of the first request
        wait_drain();
    endtask

    task automatic fill_id_window();
        test_name = "full_window";
        wb_count = 0;
        issue_burst(SEL_ADD, MAX_IDS);
        wait_drain();
        if (wb_count != MAX_IDS) begin
            other_errors++;
            $display("%s: %0d writebacks seen for %0d issued IDs", test_name, wb_count,
                     MAX_IDS);
        end
    endtask

    initial begin
        void'($urandom(32'hf553));
        rst = 1'b1;
        issue = '0;
        next_id = '0;
        value_errors = 0;
        other_errors = 0;
        wb_count = 0;
        timed_out = 1'b0;
        test_name = "reset";
        for (int k = 0; k < NUM_RCAS; k++) begin
            model_acc[k] = '0;  // Units come out of reset with a zero accumulator
            model_rs1[k] = '0;
            model_rs2[k] = '0;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (!issue_ready || wb_valid) begin
            other_errors++;
            $display("After reset issue_ready is low or wb_valid is high");
        end
        stream_single_rca();
        reuse_operands();
        mac_lanes();
        switch_rca();
        skip_unused_requests();
        fill_id_window();
        test_name = "final";
        wait_drain();
        repeat (10) @(posedge clk);  // Quiet window to catch stray writebacks
        if (exp_id.size() != 0) begin
            other_errors++;
            $display("%0d expected writebacks never arrived", exp_id.size());
        end
        end_run();
    end

endmodule

// File: hw/rca_grid.sv
module rca_grid (
    input  logic clk,
    input  logic rst,
    input  rca_pkg::rca_issue_t issue,
    output logic issue_ready,
    output logic wb_valid,
    output rca_pkg::id_t wb_id,
    output logic wb_fb_instr,
    output rca_pkg::rca_result_t wb_result
);
    import rca_pkg::*;

    logic buf_data_valid;
    logic buf_rs_data_valid;
    logic clear_fifos;
    logic wb_committing;  // Running unit has a result at its head
    rca_sel_t currently_running_rca;
    rca_sel_t rca_sel_buf;
    rca_operands_t buf_rs_data;
    logic [NUM_RCAS-1:0] unit_res_valid;
    rca_result_t unit_res [NUM_RCAS];

    grid_control u_grid_control (
        .clk,
        .rst,
        .issue,
        .issue_ready,
        .wb_committing,
        .wb_id,
        .wb_fb_instr,
        .buf_data_valid,
        .buf_rs_data_valid,
        .clear_fifos,
        .currently_running_rca,
        .buf_rs_data,
        .rca_sel_buf
    );

    // Unit index equals its KIND, so unit 0 adds and unit 1 does lane MAC
    for (genvar k = 0; k < NUM_RCAS; k++) begin : g_unit
        rca_unit #(
            .KIND(k)
        ) u_rca_unit (
            .clk,
            .rst,
            .start(buf_data_valid && (rca_sel_buf == rca_sel_t'(k))),
            .load(buf_rs_data_valid && (rca_sel_buf == rca_sel_t'(k))),
            .ops(buf_rs_data),
            .clear(clear_fifos),  // Every unit clears on a fresh start
            .pop(wb_committing && (currently_running_rca == rca_sel_t'(k))),
            .res_valid(unit_res_valid[k]),
            .res(unit_res[k])
        );
    end

    // Only one unit runs at a time so a plain select replaces an arbiter
    assign wb_committing = unit_res_valid[currently_running_rca];
    assign wb_valid = wb_committing;
    assign wb_result = unit_res[currently_running_rca];

    // The switch protocol in the controller keeps idle units silent
    assert property (@(posedge clk) disable iff (rst)
        $onehot0(unit_res_valid));

endmodule

// File: hw/rca_unit.sv
module rca_unit #(
    parameter int KIND = rca_pkg::RCA_ADD  // RCA_ADD or RCA_MAC16
) (
    input  logic clk,
    input  logic rst,
    input  logic start,  // Already gated by the unit select
    input  logic load,
    input  rca_pkg::rca_operands_t ops,
    input  logic clear,
    input  logic pop,
    output logic res_valid,
    output rca_pkg::rca_result_t res
);
    import rca_pkg::*;

    localparam int PTR_W = $clog2(MAX_IDS);
    localparam int CNT_W = $clog2(MAX_IDS + 1);

    rca_operands_t ops_r;   // Operands kept for non-feedback instructions
    rca_operands_t cur_ops;
    rca_data_u s1_next;
    rca_data_u s1_data;     // Operand combine result, before the accumulator
    logic s1_valid;
    rca_data_u acc;
    rca_data_u acc_next;
    rca_data_u s2_data;
    logic s2_valid;
    rca_result_t fifo_mem [MAX_IDS];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (load) ops_r <= ops;
    end

    assign cur_ops = load ? ops : ops_r;  // Feedback instruction uses its own fresh operands

    // Stage 1 combines the two operands
    always_comb begin
        s1_next = '0;
        if (KIND == RCA_MAC16) begin
            for (int i = 0; i < 2; i++) begin
                s1_next.half[i] = cur_ops.rs1.half[i] * cur_ops.rs2.half[i];  // Truncated product
            end
        end else begin
            s1_next.word = cur_ops.rs1.word + cur_ops.rs2.word;
        end
    end

    // Stage 2 folds in the accumulator, lanes stay separate for MAC16
    always_comb begin
        acc_next = acc;
        if (KIND == RCA_MAC16) begin
            for (int i = 0; i < 2; i++) begin
                acc_next.half[i] = acc.half[i] + s1_data.half[i];  // No carry into the other lane
            end
        end else begin
            acc_next.word = acc.word + s1_data.word;
        end
    end

    always_ff @(posedge clk) begin
        s1_data <= s1_next;
        s2_data <= acc_next;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            acc <= '0;
        end else begin
            s1_valid <= start;
            s2_valid <= s1_valid;
            if (s1_valid) acc <= acc_next;  // Ready for a start in the very next cycle
        end
    end

    always_ff @(posedge clk) begin
        if (s2_valid) fifo_mem[wr_ptr] <= '{data: s2_data};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (s2_valid) wr_ptr <= wr_ptr + 1'b1;
            if (clear) begin
                rd_ptr <= wr_ptr;               // Skips stale entries
                count <= CNT_W'(s2_valid);      // Keeps one arriving in the same cycle
            end else begin
                if (pop) rd_ptr <= rd_ptr + 1'b1;
                case ({s2_valid, pop})
                    2'b10: count <= count + 1'b1;
                    2'b01: count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end
    end

    assign res_valid = (count != '0);
    assign res = fifo_mem[rd_ptr];

    // The top only pops the running unit when its head is valid
    assert property (@(posedge clk) disable iff (rst)
        pop |-> res_valid);

endmodule

// File: hw/grid_control.sv
module grid_control (
    input  logic clk,
    input  logic rst,
    input  rca_pkg::rca_issue_t issue,
    output logic issue_ready,
    input  logic wb_committing,
    output rca_pkg::id_t wb_id,
    output logic wb_fb_instr,
    output logic buf_data_valid,     // Start strobe for the selected unit
    output logic buf_rs_data_valid,  // Operand load strobe for the selected unit
    output logic clear_fifos,        // Empties the result FIFOs on a fresh start
    output rca_pkg::rca_sel_t currently_running_rca,
    output rca_pkg::rca_operands_t buf_rs_data,
    output rca_pkg::rca_sel_t rca_sel_buf
);
    import rca_pkg::*;

    rca_issue_t issue_buf;  // Request held for one cycle and longer while waiting
    logic new_request_r;
    logic state;
    logic next_state;
    logic ids_valid;          // Some ID is still in flight
    logic accept_fire;        // Buffered request goes out from the accepting state
    logic switch_exit;        // Leaving the wait state releases the held request
    logic pending_busy;       // In flight, counting the request released this cycle
    rca_sel_t pending_sel;    // RCA that will be running once this cycle ends
    logic rca_match;
    logic [MAX_IDS-1:0] fb_table;  // Feedback flag per ID

    // Request payload qualified by new_request_r
    always_ff @(posedge clk) begin
        if (issue.new_request) issue_buf <= issue;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            new_request_r <= 1'b0;
            state <= GC_ACCEPTING;
            currently_running_rca <= '0;
        end else begin
            new_request_r <= issue.new_request;
            state <= next_state;
            if (buf_data_valid) currently_running_rca <= issue_buf.rca_sel;
        end
    end

    assign accept_fire = (state == GC_ACCEPTING) && new_request_r && issue_buf.use_instr;

    // A request released this cycle already counts as running, so a back-to-back
    // request for a different RCA cannot slip past the check
    assign pending_busy = ids_valid || accept_fire;
    assign pending_sel = accept_fire ? issue_buf.rca_sel : currently_running_rca;
    assign rca_match = pending_busy ? (pending_sel == issue.rca_sel) : 1'b1;

    always_comb begin
        next_state = state;
        case (state)
            GC_ACCEPTING: begin
                if (issue.new_request && issue.use_instr && !rca_match) next_state = GC_WAIT;
            end
            GC_WAIT: begin
                if (!ids_valid) next_state = GC_ACCEPTING;  // Old RCA has fully written back
            end
        endcase
    end

    assign issue_ready = (state == GC_ACCEPTING);
    assign switch_exit = (state == GC_WAIT) && (next_state == GC_ACCEPTING);

    assign buf_data_valid = switch_exit || accept_fire;
    assign buf_rs_data_valid = buf_data_valid && issue_buf.use_fb_instr;  // Only feedback loads

    // Nothing in flight means the target unit starts from a clean result FIFO
    assign clear_fifos = switch_exit || (accept_fire && !ids_valid);

    assign buf_rs_data = issue_buf.ops;
    assign rca_sel_buf = issue_buf.rca_sel;

    // IDs leave in issue order, matching the in-order result stream
    id_fifo u_id_fifo (
        .clk,
        .rst,
        .push(buf_data_valid),
        .pop(wb_committing),
        .data_in(issue_buf.id),
        .data_out(wb_id),
        .valid(ids_valid)
    );

    always_ff @(posedge clk) begin
        if (buf_data_valid) fb_table[issue_buf.id] <= issue_buf.use_fb_instr;
    end

    assign wb_fb_instr = fb_table[wb_id];  // Looked up at the FIFO head

    // A clear must never drop results that still owe a writeback
    assert property (@(posedge clk) disable iff (rst)
        clear_fifos |-> !wb_committing);

    // A start on another RCA only once the running one has drained
    assert property (@(posedge clk) disable iff (rst)
        buf_data_valid && (rca_sel_buf != currently_running_rca) |-> !ids_valid);

endmodule

// File: hw/id_fifo.sv
module id_fifo (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  logic pop,
    input  rca_pkg::id_t data_in,
    output rca_pkg::id_t data_out,
    output logic valid
);
    import rca_pkg::*;

    localparam int PTR_W = $clog2(MAX_IDS);
    localparam int CNT_W = $clog2(MAX_IDS + 1);

    id_t mem [MAX_IDS];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    // Entry storage
    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= data_in;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two so pointers wrap
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;  // Idle, or push and pop cancel out
            endcase
        end
    end

    // Head is visible as soon as it is written
    assign data_out = mem[rd_ptr];
    assign valid = (count != '0);

    // The issuer caps in-flight IDs at MAX_IDS, so a push into a full buffer means a lost ID
    assert property (@(posedge clk) disable iff (rst)
        push |-> (count != CNT_W'(MAX_IDS)) || pop);

    // Writeback may only commit an ID that was issued
    assert property (@(posedge clk) disable iff (rst)
        pop |-> valid);

endmodule

// File: hw/rca_pkg.sv
package rca_pkg;

    // Datapath and grid sizing
    localparam int XLEN = 32;     // Operand and result word width
    localparam int NUM_RCAS = 2;  // Accelerators in the grid
    localparam int MAX_IDS = 4;   // In-flight instructions and FIFO depth (power of two)

    // Accelerator indices double as the unit KIND parameter
    localparam int RCA_ADD = 0;    // 32-bit add-accumulate
    localparam int RCA_MAC16 = 1;  // Two-lane 16-bit multiply-accumulate

    // Issue controller FSM encodings
    localparam logic GC_ACCEPTING = 1'b0;  // Requests flow straight to the grid
    localparam logic GC_WAIT = 1'b1;       // Holding a request until the old RCA drains

    typedef logic [$clog2(MAX_IDS)-1:0] id_t;
    typedef logic [$clog2(NUM_RCAS)-1:0] rca_sel_t;

    // One operand word, viewed whole by RCA 0 or as two lanes by RCA 1
    typedef union packed {
        logic [XLEN-1:0] word;
        logic [1:0][XLEN/2-1:0] half;  // half[0] is the low lane
    } rca_data_u;

    typedef struct packed {
        rca_data_u rs1;
        rca_data_u rs2;
    } rca_operands_t;

    // Everything the issue stage presents in the cycle of new_request
    typedef struct packed {
        logic new_request;   // One-cycle strobe per instruction
        id_t id;             // Tag returned with the writeback
        rca_sel_t rca_sel;   // Target accelerator
        logic use_instr;     // Low means the request is not for the grid
        logic use_fb_instr;  // Carries fresh register operands
        rca_operands_t ops;
    } rca_issue_t;

    typedef struct packed {
        rca_data_u data;
    } rca_result_t;

endpackage
